/* hdl/cachePkg.sv */
`default_nettype none

package cachePkg;

    // Cache geometry
    localparam int lineCount  = 16;
    localparam int memDepth   = 256;
    localparam int memLatency = 4;   // Cycles from req rise to ack

    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [25:0] tagT;       // Address bits 31:6
    typedef logic [3:0]  indexT;     // Address bits 5:2
    typedef logic [1:0]  offsetT;    // Byte within word
    typedef logic [3:0]  strbT;
    typedef logic [7:0]  memAddrT;   // Word index into backing memory

    typedef logic [$clog2(memLatency)-1:0] latCntT;

endpackage

`default_nettype wire

/* hdl/memOpPkg.sv */
`default_nettype none

package memOpPkg;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } memOpT;

    typedef enum logic [1:0] {
        apbIdle,
        apbWait,
        apbDone
    } apbStateT;

    typedef enum logic [2:0] {
        ctrlIdle,
        ctrlLookup,
        ctrlRefill,
        ctrlWrite,
        ctrlRespond
    } ctrlStateT;

    function automatic logic isStore(memOpT op);
        return op inside {SB, SH, SW};
    endfunction

endpackage

`default_nettype wire

/* hdl/cacheIfs.sv */
`timescale 1ns/1ns
`default_nettype none

interface cacheReqIf;
    import cachePkg::*;
    import memOpPkg::*;

    logic  valid;   // One-cycle pulse
    addrT  addr;
    wordT  wdata;
    memOpT op;

    modport source (output valid, addr, wdata, op);
    modport sink   (input  valid, addr, wdata, op);
endinterface

interface cacheRespIf;
    import cachePkg::*;
    import memOpPkg::*;

    logic   valid;
    wordT   word;     // Raw line word, zero for stores
    offsetT offset;
    memOpT  op;
    logic   error;

    modport source (output valid, word, offset, op, error);
    modport sink   (input  valid, word, offset, op, error);
endinterface

interface memIf;
    import cachePkg::*;

    logic    req;     // Held until ack
    logic    we;
    memAddrT addr;
    strbT    wstrb;
    wordT    wdata;
    logic    ack;
    wordT    rdata;   // Valid with ack

    modport master (output req, we, addr, wstrb, wdata, input  ack, rdata);
    modport slave  (input  req, we, addr, wstrb, wdata, output ack, rdata);
endinterface

`default_nettype wire

/* hdl/apbRequestPort.sv */
`timescale 1ns/1ns
`default_nettype none

module apbRequestPort (
    input  logic             clk,
    input  logic             rstN,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  cachePkg::addrT   paddr,
    input  cachePkg::wordT   pwdata,
    input  memOpPkg::memOpT  memOp,
    input  logic             respDone,
    output logic             pready,
    cacheReqIf.source        req
);
    import memOpPkg::*;

    apbStateT state;
    logic     accessStart;

    // First access cycle of a new transfer
    assign accessStart = (state == apbIdle) && psel && penable;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= apbIdle;
            req.valid <= 1'b0;
            pready    <= 1'b0;
        end else begin
            req.valid <= 1'b0;
            pready    <= 1'b0;
            case (state)
                apbIdle: begin
                    if (accessStart) begin
                        req.valid <= 1'b1;
                        state     <= apbWait;
                    end
                end
                apbWait: begin
                    if (respDone) begin
                        pready <= 1'b1;   // Completes transfer next cycle
                        state  <= apbDone;
                    end
                end
                apbDone: state <= apbIdle;
                default: state <= apbIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accessStart) begin
            req.addr  <= paddr;
            req.op    <= memOp;
            req.wdata <= pwrite ? pwdata : '0;   // Read transfers carry no data
        end
    end

endmodule

`default_nettype wire

/* hdl/cacheController.sv */
`timescale 1ns/1ns
`default_nettype none

module cacheController (
    input  logic        clk,
    input  logic        rstN,
    cacheReqIf.sink     req,
    cacheRespIf.source  resp,
    memIf.master        mem
);
    import cachePkg::*;
    import memOpPkg::*;

    ctrlStateT            state;
    addrT                 reqAddr;
    wordT                 reqWdata;
    memOpT                reqOp;
    tagT                  tagArr [lineCount];
    wordT                 dataArr [lineCount];
    logic [lineCount-1:0] validArr;
    wordT                 respWord;
    logic                 respError;
    tagT                  reqTag;
    indexT                reqIndex;
    offsetT               reqOffset;
    logic                 hit;
    logic                 misaligned;
    logic                 badAccess;
    strbT                 storeStrb;
    wordT                 storeData;

    assign reqTag    = reqAddr[31:6];
    assign reqIndex  = reqAddr[5:2];
    assign reqOffset = reqAddr[1:0];
    assign hit       = validArr[reqIndex] && (tagArr[reqIndex] == reqTag);

    always_comb begin
        case (reqOp)
            LH, LHU, SH: misaligned = reqOffset[0];
            LW, SW:      misaligned = (reqOffset != 2'b00);
            default:     misaligned = 1'b0;
        endcase
    end

    assign badAccess = misaligned || (reqAddr >= addrT'(4 * memDepth));

    // Place store bytes in their lanes
    always_comb begin
        case (reqOp)
            SB: begin
                storeStrb = strbT'(1) << reqOffset;
                storeData = {4{reqWdata[7:0]}};
            end
            SH: begin
                storeStrb = reqOffset[1] ? 4'b1100 : 4'b0011;
                storeData = {2{reqWdata[15:0]}};
            end
            SW: begin
                storeStrb = 4'b1111;
                storeData = reqWdata;
            end
            default: begin
                storeStrb = '0;
                storeData = reqWdata;
            end
        endcase
    end

    assign mem.we      = (state == ctrlWrite);
    assign mem.addr    = reqAddr[2 +: $bits(memAddrT)];
    assign mem.wstrb   = storeStrb;
    assign mem.wdata   = storeData;

    assign resp.valid  = (state == ctrlRespond);
    assign resp.word   = respWord;
    assign resp.offset = reqOffset;
    assign resp.op     = reqOp;
    assign resp.error  = respError;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= ctrlIdle;
            mem.req  <= 1'b0;
            validArr <= '0;
        end else begin
            case (state)
                ctrlIdle: if (req.valid) state <= ctrlLookup;
                ctrlLookup: begin
                    if (badAccess) begin
                        state <= ctrlRespond;   // Skips memory
                    end else if (isStore(reqOp)) begin
                        mem.req <= 1'b1;
                        state   <= ctrlWrite;
                    end else if (hit) begin
                        state <= ctrlRespond;
                    end else begin
                        mem.req <= 1'b1;
                        state   <= ctrlRefill;
                    end
                end
                ctrlRefill: begin
                    if (mem.ack) begin
                        mem.req            <= 1'b0;
                        validArr[reqIndex] <= 1'b1;
                        state              <= ctrlRespond;
                    end
                end
                ctrlWrite: begin
                    if (mem.ack) begin
                        mem.req <= 1'b0;
                        state   <= ctrlRespond;
                    end
                end
                default: state <= ctrlIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ctrlIdle: begin
                if (req.valid) begin
                    reqAddr  <= req.addr;
                    reqWdata <= req.wdata;
                    reqOp    <= req.op;
                end
            end
            ctrlLookup: begin
                respError <= badAccess;
                respWord  <= (badAccess || isStore(reqOp)) ? '0 : dataArr[reqIndex];
                if (!badAccess && isStore(reqOp) && hit) begin   // Merge on store hit
                    for (int b = 0; b < 4; b++) begin
                        if (storeStrb[b]) begin
                            dataArr[reqIndex][8*b +: 8] <= storeData[8*b +: 8];
                        end
                    end
                end
            end
            ctrlRefill: begin
                if (mem.ack) begin
                    dataArr[reqIndex] <= mem.rdata;
                    tagArr[reqIndex]  <= reqTag;
                    respWord          <= mem.rdata;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mainMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module mainMemory (
    input  logic clk,
    input  logic rstN,
    memIf.slave  mem
);
    import cachePkg::*;

    wordT   memArr [memDepth];
    latCntT latCnt;
    logic   ackNow;

    // Last wait cycle of a pending request
    assign ackNow = mem.req && !mem.ack && (latCnt == latCntT'(memLatency - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            latCnt  <= '0;
            mem.ack <= 1'b0;
        end else if (mem.ack) begin
            mem.ack <= 1'b0;
        end else if (ackNow) begin
            mem.ack <= 1'b1;
            latCnt  <= '0;
        end else if (mem.req) begin
            latCnt <= latCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ackNow) begin
            mem.rdata <= memArr[mem.addr];
            if (mem.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem.wstrb[b]) begin
                        memArr[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/loadFormatter.sv */
`timescale 1ns/1ns
`default_nettype none

module loadFormatter (
    input  logic            clk,
    input  logic            rstN,
    cacheRespIf.sink        resp,
    output cachePkg::wordT  prdata,
    output logic            pslverr,
    output logic            respDone
);
    import cachePkg::*;
    import memOpPkg::*;

    wordT        formatted;
    wordT        dataQ;
    logic        errQ;
    logic [7:0]  lane8;
    logic [15:0] lane16;

    assign lane8  = resp.word[8*resp.offset +: 8];
    assign lane16 = resp.offset[1] ? resp.word[31:16] : resp.word[15:0];

    always_comb begin
        case (resp.op)
            LB:      formatted = {{24{lane8[7]}}, lane8};
            LBU:     formatted = {24'b0, lane8};
            LH:      formatted = {{16{lane16[15]}}, lane16};
            LHU:     formatted = {16'b0, lane16};
            LW:      formatted = resp.word;
            default: formatted = '0;   // Stores return nothing
        endcase
        if (resp.error) begin
            formatted = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            respDone <= 1'b0;
            pslverr  <= 1'b0;
        end else begin
            respDone <= resp.valid;
            pslverr  <= respDone && errQ;   // Lines up with pready
        end
    end

    always_ff @(posedge clk) begin
        if (resp.valid) begin
            dataQ <= formatted;
            errQ  <= resp.error;
        end
        if (respDone) begin
            prdata <= dataQ;
        end
    end

endmodule

`default_nettype wire

/* hdl/cacheTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cacheTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  cachePkg::addrT   paddr,
    input  cachePkg::wordT   pwdata,
    input  memOpPkg::memOpT  memOp,
    output cachePkg::wordT   prdata,
    output logic             pready,
    output logic             pslverr
);

    logic respDone;

    cacheReqIf  reqIf ();
    cacheRespIf respIf ();
    memIf       memBus ();

    apbRequestPort u_apbRequestPort (
        .clk      (clk),
        .rstN     (rstN),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .memOp    (memOp),
        .respDone (respDone),
        .pready   (pready),
        .req      (reqIf.source)
    );

    cacheController u_cacheController (
        .clk  (clk),
        .rstN (rstN),
        .req  (reqIf.sink),
        .resp (respIf.source),
        .mem  (memBus.master)
    );

    mainMemory u_mainMemory (
        .clk  (clk),
        .rstN (rstN),
        .mem  (memBus.slave)
    );

    loadFormatter u_loadFormatter (
        .clk      (clk),
        .rstN     (rstN),
        .resp     (respIf.sink),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .respDone (respDone)
    );

endmodule

`default_nettype wire

/* testbench/cacheTop_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module cacheTop_assert (
    input logic clk,
    input logic rstN,
    input logic psel,
    input logic pready,
    input logic pslverr,
    input logic memReq,
    input logic memAck
);

    int unsigned failCount = 0;   // Failed assertion count

    readyNeedsSel: assert property (@(posedge clk) disable iff (!rstN)
        $rose(pready) |-> psel)
        else begin
            $error("pready rose while psel was low");
            failCount++;
        end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        memAck |-> memReq)
        else begin
            $error("memory ack without a pending req");
            failCount++;
        end

    errWithReady: assert property (@(posedge clk) disable iff (!rstN)
        pslverr |-> pready)
        else begin
            $error("pslverr high outside the pready cycle");
            failCount++;
        end

endmodule

bind cacheTop cacheTop_assert u_cacheTopAssert (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .pready  (pready),
    .pslverr (pslverr),
    .memReq  (memBus.req),
    .memAck  (memBus.ack)
);

`default_nettype wire

/* testbench/cacheTop_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cacheTop_tb;
    import cachePkg::*;
    import memOpPkg::*;

    typedef struct packed {
        addrT  addr;
        memOpT op;
        wordT  wdata;
        wordT  rdata;
        logic  err;
    } txnT;

    localparam int seed      = 46171;
    localparam int txnCount  = 3 * memDepth + 52 + 24 + 16 + 13 + 300;
    localparam int timeLimit = 400 * txnCount + 16 * 4;   // Reset included

    logic  clk = 1'b0;
    logic  rstN;
    logic  psel;
    logic  penable;
    logic  pwrite;
    addrT  paddr;
    wordT  pwdata;
    memOpT memOp;
    wordT  prdata;
    logic  pready;
    logic  pslverr;

    wordT  modelMem [memDepth];
    txnT   txnQ [$];
    string testName;
    int    errorCount = 0;
    int    checkCount = 0;
    int    testCount = 0;
    int    testErrBase = 0;
    wordT  pattern [4] = '{32'h8001_7FFE, 32'h7F80_FF01, 32'hFFFF_0000, 32'h1234_ABCD};

    cacheTop u_cacheTop (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .memOp   (memOp),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #2 clk = ~clk;

    function automatic logic accessError(addrT addr, memOpT op);
        int unsigned size;
        case (op)
            LB, LBU, SB: size = 1;
            LH, LHU, SH: size = 2;
            default:     size = 4;
        endcase
        return ((addr % size) != 0) || (addr >= 32'd1024);   // Memory ends at byte 1024
    endfunction

    function automatic wordT expectLoad(addrT addr, memOpT op, output logic err);
        wordT        w;
        logic [7:0]  b;
        logic [15:0] h;
        err = accessError(addr, op);
        w = modelMem[addr[9:2]];
        b = w[8 * addr[1:0] +: 8];
        h = w[16 * addr[1] +: 16];
        if (err) begin
            return '0;
        end
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            LW:      return w;
            default: return '0;   // Stores read back zero
        endcase
    endfunction

    function automatic void storeModel(addrT addr, memOpT op, wordT wdata);
        case (op)
            SB:      modelMem[addr[9:2]][8 * addr[1:0] +: 8] = wdata[7:0];
            SH:      modelMem[addr[9:2]][16 * addr[1] +: 16] = wdata[15:0];
            SW:      modelMem[addr[9:2]] = wdata;
            default: ;
        endcase
    endfunction

    task automatic checkData(addrT addr, memOpT op, wordT expected, wordT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s addr %h op %s prdata expected %h actual %h",
                     testName, addr, op.name(), expected, actual);
        end
    endtask

    task automatic checkError(addrT addr, memOpT op, logic expected, logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s addr %h op %s pslverr expected %b actual %b",
                     testName, addr, op.name(), expected, actual);
        end
    endtask

    task automatic apbTransfer(logic write, addrT addr, memOpT op, wordT wdata);
        txnT t;
        @(posedge clk);
        #1;
        psel    = 1'b1;   // Setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        memOp   = op;
        @(posedge clk);
        #1;
        penable = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!pready);
        t.addr  = addr;
        t.op    = op;
        t.wdata = wdata;
        t.rdata = prdata;
        t.err   = pslverr;
        txnQ.push_back(t);
        @(posedge clk);   // Transfer completes on this edge
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(addrT addr, memOpT op, wordT wdata);
        apbTransfer(1'b1, addr, op, wdata);
    endtask

    task automatic apbRead(addrT addr, memOpT op);
        apbTransfer(1'b0, addr, op, '0);
    endtask

    task automatic startTest(string name);
        testName    = name;
        testErrBase = errorCount;
        testCount++;
    endtask

    task automatic endTest();
        while (txnQ.size() != 0) begin
            @(posedge clk);
        end
        #1;
        $display("Test %0d %s: %0d errors", testCount, testName, errorCount - testErrBase);
    endtask

    // Compare against the model in issue order
    initial begin
        txnT  t;
        wordT expData;
        logic expErr;
        forever begin
            @(posedge clk);
            while (txnQ.size() > 0) begin
                t = txnQ.pop_front();
                expData = expectLoad(t.addr, t.op, expErr);
                checkData(t.addr, t.op, expData, t.rdata);
                checkError(t.addr, t.op, expErr, t.err);
                if (!expErr) begin
                    storeModel(t.addr, t.op, t.wdata);
                end
            end
        end
    end

    initial begin
        #(timeLimit);
        $display("Timeout: run did not finish within %0d ns", timeLimit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        addrT  a;
        addrT  oldAddr;
        addrT  newAddr;
        memOpT op;
        int    assertFails;
        void'($urandom(seed));
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        memOp   = LW;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;

        startTest("word fill and readback");
        for (int i = 0; i < memDepth; i++) begin
            apbWrite(addrT'(4 * i), SW, $urandom());
        end
        for (int i = 0; i < memDepth; i++) begin
            apbRead(addrT'(4 * i), LW);   // Refill
            apbRead(addrT'(4 * i), LW);   // Hit
        end
        endTest();

        startTest("sub-word loads");
        for (int w = 0; w < 4; w++) begin
            a = addrT'(64 * w + 8);
            apbWrite(a, SW, pattern[w]);
            for (int off = 0; off < 4; off++) begin
                apbRead(a + addrT'(off), LB);
                apbRead(a + addrT'(off), LBU);
            end
            for (int off = 0; off < 4; off += 2) begin
                apbRead(a + addrT'(off), LH);
                apbRead(a + addrT'(off), LHU);
            end
        end
        endTest();

        startTest("store merge on hit");
        for (int k = 0; k < 8; k++) begin
            a = addrT'($urandom_range(0, 255) * 4);
            apbRead(a, LW);
            if (k % 2 == 1) begin
                apbWrite(a + addrT'($urandom_range(0, 3)), SB, $urandom());
            end else begin
                apbWrite(a + addrT'(2 * $urandom_range(0, 1)), SH, $urandom());
            end
            apbRead(a, LW);
        end
        endTest();

        startTest("write-through no allocate");
        for (int k = 0; k < 4; k++) begin
            oldAddr = addrT'(64 * k + 4 * (3 * k + 1));
            newAddr = oldAddr + addrT'(64 * 8);   // Same index, other tag
            apbRead(oldAddr, LW);
            apbWrite(newAddr + addrT'($urandom_range(0, 3)), SB, $urandom());
            apbRead(oldAddr, LW);
            apbRead(newAddr, LW);
        end
        endTest();

        startTest("error responses");
        a = 32'h100;
        apbRead(32'h200, LW);   // Other tag in line 0, so the final reads miss
        apbRead(a + 1, LH);
        apbRead(a + 3, LHU);
        apbWrite(a + 1, SH, 32'hDEAD_BEEF);
        apbRead(a + 2, LW);
        apbWrite(a + 2, SW, 32'hCAFE_F00D);
        apbWrite(a + 3, SW, 32'h0BAD_0BAD);
        apbWrite(32'h400, SW, 32'h5555_AAAA);   // Would alias word 0
        apbRead(32'h404, LB);
        apbWrite(32'hFFFF_FFF0, SB, 32'h0000_00EE);
        apbRead(32'h400 + a, LW);
        apbRead(a, LW);
        apbRead(32'h0, LW);
        endTest();

        startTest("random mix");
        for (int i = 0; i < 300; i++) begin
            op = memOpT'(3'($urandom_range(0, 7)));
            if ($urandom_range(0, 7) == 0) begin
                a = addrT'(1024 + $urandom_range(0, 8191));
            end else begin
                a = addrT'($urandom_range(0, 1023));
            end
            if (op inside {SB, SH, SW}) begin
                apbWrite(a, op, $urandom());
            end else begin
                apbRead(a, op);
            end
        end
        endTest();

        assertFails = u_cacheTop.u_cacheTopAssert.failCount;
        if (assertFails != 0) begin
            $display("Assertion failures during run: %0d", assertFails);
        end
        errorCount += assertFails;
        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/cachePkg.sv
hdl/memOpPkg.sv
hdl/cacheIfs.sv
hdl/apbRequestPort.sv
hdl/cacheController.sv
hdl/mainMemory.sv
hdl/loadFormatter.sv
hdl/cacheTop.sv
testbench/cacheTop_assert.sv
testbench/cacheTop_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns --top-module cacheTop_tb \
    -f project.f --Mdir obj_dir -o simv

./obj_dir/simv +verilator+error+limit+100 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run reported errors, see sim.log"
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "Run ended without a result line, see sim.log"
    exit 1
fi
